//--- hdl/decode_pkg.sv
//####################
// Decoded instruction types for the register access stage
// Operand kinds, stack operation, decode bundle and stage output bundle
//####################

package decode_pkg;

    // Where an operand takes its register number from
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        REG       = 3'd1,
        MEM       = 3'd2,
        MODRM_REG = 3'd4
    } op_kind_t;

    // Push and pop are never requested together
    typedef struct packed {
        logic pop;
        logic push;
    } stack_op_t;

    // Fields of a decoded instruction used or passed on by this stage
    typedef struct packed {
        logic [15:0] opcode;
        logic [2:0]  size;
        op_kind_t    op0_kind;
        op_kind_t    op1_kind;
        logic [2:0]  op0_reg;
        logic [2:0]  op1_reg;
        logic [7:0]  modrm;
        logic [2:0]  seg_override;
        logic        seg_override_valid;
        stack_op_t   stack_op;
        logic        dest_valid;
        logic [2:0]  dest_reg;
    } decode_bundle_t;

    // Handed to address generation
    typedef struct packed {
        decode_bundle_t instr;
        logic [2:0]     op0_sel;
        logic [2:0]     op1_sel;
        logic [31:0]    op0_value;
        logic [31:0]    op1_value;
        logic [15:0]    seg_value;
        logic [31:0]    stack_address;
    } access_bundle_t;

endpackage

//--- hdl/regfile_pkg.sv
//####################
// Register numbers, write size codes and writeback bundles
//####################

package regfile_pkg;

    localparam int NUM_REGS = 8;
    localparam int NUM_SEGS = 6;

    // General register holding the stack pointer
    localparam logic [2:0] ESP_INDEX = 3'd4;

    // Segment numbers ES 0, CS 1, SS 2, DS 3, FS 4, GS 5
    localparam logic [2:0] CS_INDEX = 3'd1;
    localparam logic [2:0] SS_INDEX = 3'd2;
    localparam logic [2:0] DS_INDEX = 3'd3;

    localparam logic [2:0] SIZE_BYTE  = 3'd0;
    localparam logic [2:0] SIZE_WORD  = 3'd1;
    localparam logic [2:0] SIZE_DWORD = 3'd2;

    typedef struct packed {
        logic        en;
        logic        stack;
        logic [2:0]  number;
        logic [2:0]  size;
        logic [31:0] data;
    } reg_wb_t;

    typedef struct packed {
        logic        en;
        logic [2:0]  number;
        logic [15:0] data;
    } seg_wb_t;

endpackage

//--- hdl/register_access_stall.sv
//####################
// Pending-write scoreboard for the general registers
// Holds back readers of registers with writes in flight
//####################

`timescale 1ns/1ps

module register_access_stall (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 accept,
    input  logic                 dest_valid,
    input  logic [2:0]           dest_reg,
    input  logic                 op0_used,
    input  logic [2:0]           op0_sel,
    input  logic                 op1_used,
    input  logic [2:0]           op1_sel,
    input  logic                 stack_used,
    input  regfile_pkg::reg_wb_t wb,
    output logic                 stall
);

    logic [1:0] pending [regfile_pkg::NUM_REGS];
    logic [regfile_pkg::NUM_REGS-1:0] issue;
    logic [regfile_pkg::NUM_REGS-1:0] retire;
    logic op0_busy;
    logic op1_busy;
    logic esp_busy;

    always_comb begin
        for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
            issue[i]  = accept && dest_valid && (dest_reg == 3'(i));
            retire[i] = wb.en && (wb.number == 3'(i));
        end
    end

    // Issue and retire together leave the count unchanged
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
                pending[i] <= 2'd0;
            end
        end else begin
            for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
                if (issue[i] && !retire[i] && (pending[i] != 2'd3)) begin
                    pending[i] <= pending[i] + 2'd1;
                end else if (retire[i] && !issue[i] && (pending[i] != 2'd0)) begin
                    // Late writebacks of flushed work do not wrap the count
                    pending[i] <= pending[i] - 2'd1;
                end
            end
        end
    end

    assign op0_busy = op0_used && (pending[op0_sel] != 2'd0);
    assign op1_busy = op1_used && (pending[op1_sel] != 2'd0);
    assign esp_busy = stack_used && (pending[regfile_pkg::ESP_INDEX] != 2'd0);
    assign stall    = op0_busy || op1_busy || esp_busy;

endmodule

//--- hdl/register_access_top.sv
//####################
// Register access stage
// Operand selection, handshake, output pipe register and
// the register files, scoreboard and stack pointer instances
//####################

`timescale 1ns/1ps

module register_access_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic [15:0]                write_cs,
    input  logic                       write_cs_enable,
    input  logic                       d_valid,
    output logic                       d_ready,
    input  decode_pkg::decode_bundle_t d_bundle,
    output logic                       r_valid,
    input  logic                       r_ready,
    output decode_pkg::access_bundle_t r_bundle,
    input  regfile_pkg::reg_wb_t       wb_reg,
    input  regfile_pkg::seg_wb_t       wb_seg
);

    logic [2:0]  op0_sel;
    logic [2:0]  op1_sel;
    logic        op0_used;
    logic        op1_used;
    logic        stack_used;
    logic [31:0] op0_value;
    logic [31:0] op1_value;
    logic [15:0] seg_value;
    logic [15:0] ss_value;
    logic [31:0] stack_address;
    logic        stall;
    logic        accept;
    decode_pkg::access_bundle_t next_bundle;

    // ModR/M r/m field for MODRM_REG, the decoded reg field otherwise
    function automatic logic [2:0] operand_sel(
        input decode_pkg::op_kind_t kind,
        input logic [2:0]           reg_field,
        input logic [7:0]           modrm
    );
        return (kind == decode_pkg::MODRM_REG) ? modrm[2:0] : reg_field;
    endfunction

    function automatic logic operand_reads_reg(input decode_pkg::op_kind_t kind);
        return (kind == decode_pkg::REG) || (kind == decode_pkg::MODRM_REG);
    endfunction

    assign op0_sel = operand_sel(d_bundle.op0_kind, d_bundle.op0_reg, d_bundle.modrm);
    assign op1_sel = operand_sel(d_bundle.op1_kind, d_bundle.op1_reg, d_bundle.modrm);

    // Only a valid instruction can stall the stage
    assign op0_used   = d_valid && operand_reads_reg(d_bundle.op0_kind);
    assign op1_used   = d_valid && operand_reads_reg(d_bundle.op1_kind);
    assign stack_used = d_valid && (d_bundle.stack_op.push || d_bundle.stack_op.pop);

    assign d_ready = !stall && (!r_valid || r_ready);
    assign accept  = d_valid && d_ready;

    always_comb begin
        next_bundle               = '0;
        next_bundle.instr         = d_bundle;
        next_bundle.op0_sel       = op0_sel;
        next_bundle.op1_sel       = op1_sel;
        next_bundle.op0_value     = op0_value;
        next_bundle.op1_value     = op1_value;
        next_bundle.seg_value     = seg_value;
        next_bundle.stack_address = stack_address;
    end

    // An accept in a flush cycle is dropped
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_bundle <= next_bundle;
        end
    end

    register_file register_file0 (
        .clk       (clk),
        .reset     (reset),
        .wb        (wb_reg),
        .rd0_sel   (op0_sel),
        .rd1_sel   (op1_sel),
        .rd0_value (op0_value),
        .rd1_value (op1_value)
    );

    segment_register_file segment_register_file0 (
        .clk                (clk),
        .reset              (reset),
        .wb                 (wb_seg),
        .write_cs           (write_cs),
        .write_cs_enable    (write_cs_enable),
        .seg_override       (d_bundle.seg_override),
        .seg_override_valid (d_bundle.seg_override_valid),
        .seg_value          (seg_value),
        .ss_value           (ss_value)
    );

    register_access_stall register_access_stall0 (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .accept     (accept),
        .dest_valid (d_bundle.dest_valid),
        .dest_reg   (d_bundle.dest_reg),
        .op0_used   (op0_used),
        .op0_sel    (op0_sel),
        .op1_used   (op1_used),
        .op1_sel    (op1_sel),
        .stack_used (stack_used),
        .wb         (wb_reg),
        .stall      (stall)
    );

    stack_pointer_tracker stack_pointer_tracker0 (
        .clk           (clk),
        .reset         (reset),
        .accept        (accept),
        .stack_op      (d_bundle.stack_op),
        .size          (d_bundle.size),
        .ss_value      (ss_value),
        .wb            (wb_reg),
        .stack_address (stack_address)
    );

endmodule

//--- hdl/register_file.sv
//####################
// Eight 32-bit general registers
// Size-masked writeback and two combinational read ports
//####################

`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  regfile_pkg::reg_wb_t wb,
    input  logic [2:0]           rd0_sel,
    input  logic [2:0]           rd1_sel,
    output logic [31:0]          rd0_value,
    output logic [31:0]          rd1_value
);

    logic [31:0] regs [regfile_pkg::NUM_REGS];
    logic [31:0] merged;

    // Old register value with the written part replaced
    always_comb begin
        merged = regs[wb.number];
        case (wb.size)
            regfile_pkg::SIZE_BYTE: begin
                merged[7:0] = wb.data[7:0];
            end
            regfile_pkg::SIZE_WORD: begin
                merged[15:0] = wb.data[15:0];
            end
            regfile_pkg::SIZE_DWORD: begin
                merged = wb.data;
            end
            default: begin
                // Unused size codes leave the register as it is
                merged = regs[wb.number];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.number] <= merged;
        end
    end

    // A same-cycle writeback shows up on the next read
    assign rd0_value = regs[rd0_sel];
    assign rd1_value = regs[rd1_sel];

endmodule

//--- hdl/segment_register_file.sv
//####################
// Six 16-bit segment registers
// Writeback, direct CS write and override selection
//####################

`timescale 1ns/1ps

module segment_register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  regfile_pkg::seg_wb_t wb,
    input  logic [15:0]          write_cs,
    input  logic                 write_cs_enable,
    input  logic [2:0]           seg_override,
    input  logic                 seg_override_valid,
    output logic [15:0]          seg_value,
    output logic [15:0]          ss_value
);

    logic [15:0] segs [regfile_pkg::NUM_SEGS];
    logic [2:0]  seg_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regfile_pkg::NUM_SEGS; i++) begin
                segs[i] <= '0;
            end
        end else begin
            if (wb.en && (int'(wb.number) < regfile_pkg::NUM_SEGS)) begin
                segs[wb.number] <= wb.data;
            end
            // Direct CS write comes last so it wins over a CS writeback
            if (write_cs_enable) begin
                segs[regfile_pkg::CS_INDEX] <= write_cs;
            end
        end
    end

    // Default data segment unless the instruction overrides it
    assign seg_sel = seg_override_valid ? seg_override : regfile_pkg::DS_INDEX;

    // Codes 6 and 7 name no segment and read as zero
    assign seg_value = (int'(seg_sel) < regfile_pkg::NUM_SEGS) ? segs[seg_sel] : 16'd0;
    assign ss_value  = segs[regfile_pkg::SS_INDEX];

endmodule

//--- hdl/stack_pointer_tracker.sv
//####################
// Working ESP for push and pop
// Speculative update at accept and real-mode stack address
//####################

`timescale 1ns/1ps

module stack_pointer_tracker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  accept,
    input  decode_pkg::stack_op_t stack_op,
    input  logic [2:0]            size,
    input  logic [15:0]           ss_value,
    input  regfile_pkg::reg_wb_t  wb,
    output logic [31:0]           stack_address
);

    logic [31:0] esp_work;
    logic [31:0] step;
    logic [31:0] esp_push;
    logic [31:0] esp_pop;
    logic [31:0] ss_base;
    logic        reload;

    // Word operations move ESP by 2, everything else by 4
    assign step     = (size == regfile_pkg::SIZE_WORD) ? 32'd2 : 32'd4;
    assign esp_push = esp_work - step;
    assign esp_pop  = esp_work + step;

    // SS shifted left by four
    assign ss_base = {12'd0, ss_value, 4'd0};

    // Non-stack write to ESP replaces the working copy
    assign reload = wb.en && !wb.stack && (wb.number == regfile_pkg::ESP_INDEX);

    // Push addresses the decremented ESP, pop the current one
    always_comb begin
        if (stack_op.pop) begin
            stack_address = ss_base + esp_work;
        end else if (stack_op.push) begin
            stack_address = ss_base + esp_push;
        end else begin
            stack_address = 32'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            esp_work <= 32'd0;
        end else if (reload) begin
            esp_work <= wb.data;
        end else if (accept && stack_op.push) begin
            esp_work <= esp_push;
        end else if (accept && stack_op.pop) begin
            esp_work <= esp_pop;
        end
    end

endmodule

//--- register_access_top.f
hdl/decode_pkg.sv
hdl/regfile_pkg.sv
hdl/register_file.sv
hdl/segment_register_file.sv
hdl/register_access_stall.sv
hdl/stack_pointer_tracker.sv
hdl/register_access_top.sv
testbench/register_access_props.sv
testbench/register_access_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the register access stage testbench with Verilator and runs it

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
    -f register_access_top.f \
    --top-module register_access_tb \
    --Mdir "$OBJ_DIR" \
    -o register_access_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/register_access_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0

//--- testbench/register_access_props.sv
//####################
// Handshake assertions for the register access stage
// Bound into register_access_top
//####################

`timescale 1ns/1ps

module register_access_props (
    input logic                       clk,
    input logic                       reset,
    input logic                       flush,
    input logic                       r_valid,
    input logic                       r_ready,
    input decode_pkg::access_bundle_t r_bundle,
    input logic                       d_ready,
    input logic                       stall,
    input regfile_pkg::reg_wb_t       wb_reg
);

    // Output must hold while the next stage is not ready
    property output_holds;
        @(posedge clk) disable iff (reset)
        (r_valid && !r_ready && !flush) |=> (r_valid && $stable(r_bundle));
    endproperty

    property flush_drops_output;
        @(posedge clk) disable iff (reset)
        flush |=> !r_valid;
    endproperty

    // A stalled instruction waits until a writeback or flush frees its source
    property stall_blocks_ready;
        @(posedge clk) disable iff (reset)
        (stall && !wb_reg.en && !flush) |=> !d_ready;
    endproperty

    hold_check: assert property (output_holds)
        else $error("r_bundle or r_valid changed while r_ready was low");
    flush_check: assert property (flush_drops_output)
        else $error("r_valid still high in the cycle after flush");
    stall_check: assert property (stall_blocks_ready)
        else $error("d_ready rose after a stall with no writeback or flush");

endmodule

//--- testbench/register_access_tb.sv
//####################
// Testbench for the register access stage
// Clock, reset, stimulus, reference model and compare process
//####################

`timescale 1ns/1ps

module register_access_tb;

    localparam int NUM_RESET_INSTR = 3;
    localparam int NUM_SIZE_INSTR  = 24;
    localparam int NUM_SEG_INSTR   = 12;
    localparam int NUM_DEP_PAIRS   = 4;
    localparam int NUM_STACK_INSTR = 8;
    localparam int TOTAL_INSTR     = NUM_RESET_INSTR + NUM_SIZE_INSTR + NUM_SEG_INSTR + 1
                                   + 2 * NUM_DEP_PAIRS + 2 * NUM_STACK_INSTR + 4;
    localparam int CYCLE_LIMIT     = 40 * TOTAL_INSTR;

    logic                       clk;
    logic                       reset;
    logic                       flush;
    logic [15:0]                write_cs;
    logic                       write_cs_enable;
    logic                       d_valid;
    logic                       d_ready;
    decode_pkg::decode_bundle_t d_bundle;
    logic                       r_valid;
    logic                       r_ready;
    decode_pkg::access_bundle_t r_bundle;
    regfile_pkg::reg_wb_t       wb_reg;
    regfile_pkg::seg_wb_t       wb_seg;

    // Reference model state
    logic [31:0] regs_m [8];
    logic [15:0] segs_m [8];
    logic [31:0] esp_m;
    int          pending_m [8];
    decode_pkg::access_bundle_t expected_q [$];

    logic [31:0] lcg_state = 32'd53;
    logic        accepted;
    int          cycle_count;

    register_access_top dut0 (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .write_cs        (write_cs),
        .write_cs_enable (write_cs_enable),
        .d_valid         (d_valid),
        .d_ready         (d_ready),
        .d_bundle        (d_bundle),
        .r_valid         (r_valid),
        .r_ready         (r_ready),
        .r_bundle        (r_bundle),
        .wb_reg          (wb_reg),
        .wb_seg          (wb_seg)
    );

    bind register_access_top register_access_props props0 (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_bundle (r_bundle),
        .d_ready  (d_ready),
        .stall    (stall),
        .wb_reg   (wb_reg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the stage stopped making progress", cycle_count);
            stop_on_error();
        end
    end

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic decode_pkg::op_kind_t kind_from(input logic [1:0] code);
        case (code)
            2'd0: return decode_pkg::NONE;
            2'd1: return decode_pkg::REG;
            2'd2: return decode_pkg::MEM;
            default: return decode_pkg::MODRM_REG;
        endcase
    endfunction

    function automatic decode_pkg::decode_bundle_t random_instr();
        decode_pkg::decode_bundle_t b;
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = rand_next();
        r1 = rand_next();
        b = '0;
        b.opcode = r0[15:0];
        b.size = r0[16] ? regfile_pkg::SIZE_WORD : regfile_pkg::SIZE_DWORD;
        b.op0_kind = kind_from(r0[18:17]);
        b.op1_kind = kind_from(r0[20:19]);
        b.op0_reg = r0[23:21];
        b.op1_reg = r0[26:24];
        b.modrm = r1[7:0];
        b.seg_override = r1[10:8] % 3'd6;
        b.seg_override_valid = r1[11];
        return b;
    endfunction

    // Register number an operand reads
    function automatic logic [2:0] operand_register(input decode_pkg::op_kind_t kind,
                                                    input logic [2:0] reg_field,
                                                    input logic [7:0] modrm);
        if (kind == decode_pkg::MODRM_REG) begin
            return modrm[2:0];
        end
        return reg_field;
    endfunction

    function automatic logic stall_expected(input decode_pkg::decode_bundle_t b);
        logic busy;
        busy = 1'b0;
        if ((b.op0_kind == decode_pkg::REG || b.op0_kind == decode_pkg::MODRM_REG) &&
            pending_m[operand_register(b.op0_kind, b.op0_reg, b.modrm)] != 0) begin
            busy = 1'b1;
        end
        if ((b.op1_kind == decode_pkg::REG || b.op1_kind == decode_pkg::MODRM_REG) &&
            pending_m[operand_register(b.op1_kind, b.op1_reg, b.modrm)] != 0) begin
            busy = 1'b1;
        end
        if ((b.stack_op.push || b.stack_op.pop) &&
            pending_m[regfile_pkg::ESP_INDEX] != 0) begin
            busy = 1'b1;
        end
        return busy;
    endfunction

    // Expected stage output for an instruction accepted now
    function automatic decode_pkg::access_bundle_t expected_bundle(
        input decode_pkg::decode_bundle_t b
    );
        decode_pkg::access_bundle_t e;
        logic [2:0]  seg_num;
        logic [31:0] step;
        logic [31:0] ss_base;
        e = '0;
        e.instr = b;
        e.op0_sel = operand_register(b.op0_kind, b.op0_reg, b.modrm);
        e.op1_sel = operand_register(b.op1_kind, b.op1_reg, b.modrm);
        e.op0_value = regs_m[e.op0_sel];
        e.op1_value = regs_m[e.op1_sel];
        seg_num = b.seg_override_valid ? b.seg_override : regfile_pkg::DS_INDEX;
        e.seg_value = segs_m[seg_num];
        step = (b.size == regfile_pkg::SIZE_WORD) ? 32'd2 : 32'd4;
        ss_base = {16'd0, segs_m[regfile_pkg::SS_INDEX]} * 32'd16;
        if (b.stack_op.push) begin
            e.stack_address = ss_base + esp_m - step;
        end else if (b.stack_op.pop) begin
            e.stack_address = ss_base + esp_m;
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    // Sample at the falling edge, update the model and drive after the rise
    task automatic tick();
        logic issue;
        @(negedge clk);
        accepted = 1'b0;
        assert (!(d_valid && stall_expected(d_bundle) && d_ready)) else begin
            $display("d_ready high at %0t ns while a source write is pending", $time);
            stop_on_error();
        end
        issue = 1'b0;
        if (d_valid && d_ready) begin
            accepted = 1'b1;
            expected_q.push_back(expected_bundle(d_bundle));
            issue = d_bundle.dest_valid;
            if (d_bundle.stack_op.push) begin
                esp_m = esp_m - ((d_bundle.size == regfile_pkg::SIZE_WORD) ? 32'd2 : 32'd4);
            end else if (d_bundle.stack_op.pop) begin
                esp_m = esp_m + ((d_bundle.size == regfile_pkg::SIZE_WORD) ? 32'd2 : 32'd4);
            end
        end
        if (issue && !(wb_reg.en && wb_reg.number == d_bundle.dest_reg) &&
            pending_m[d_bundle.dest_reg] < 3) begin
            pending_m[d_bundle.dest_reg]++;
        end
        if (wb_reg.en) begin
            if (!(issue && wb_reg.number == d_bundle.dest_reg) &&
                pending_m[wb_reg.number] > 0) begin
                pending_m[wb_reg.number]--;
            end
            case (wb_reg.size)
                regfile_pkg::SIZE_BYTE: regs_m[wb_reg.number][7:0] = wb_reg.data[7:0];
                regfile_pkg::SIZE_WORD: regs_m[wb_reg.number][15:0] = wb_reg.data[15:0];
                regfile_pkg::SIZE_DWORD: regs_m[wb_reg.number] = wb_reg.data;
                default: begin
                end
            endcase
            if (!wb_reg.stack && wb_reg.number == regfile_pkg::ESP_INDEX) begin
                esp_m = wb_reg.data;
            end
        end
        if (wb_seg.en && wb_seg.number < 3'd6) begin
            segs_m[wb_seg.number] = wb_seg.data;
        end
        // Direct CS write wins over a CS writeback
        if (write_cs_enable) begin
            segs_m[regfile_pkg::CS_INDEX] = write_cs;
        end
        if (flush) begin
            expected_q.delete();
            for (int i = 0; i < 8; i++) begin
                pending_m[i] = 0;
            end
        end
        @(posedge clk);
        #2;
        wb_reg.en = 1'b0;
        wb_seg.en = 1'b0;
        write_cs_enable = 1'b0;
        flush = 1'b0;
        if (accepted) begin
            d_valid = 1'b0;
        end
    endtask

    task automatic present(input decode_pkg::decode_bundle_t b);
        d_valid = 1'b1;
        d_bundle = b;
    endtask

    task automatic send(input decode_pkg::decode_bundle_t b);
        present(b);
        do begin
            tick();
        end while (!accepted);
    endtask

    task automatic write_reg(input logic [2:0] number, input logic [2:0] size,
                             input logic [31:0] data, input logic stack);
        wb_reg.en = 1'b1;
        wb_reg.stack = stack;
        wb_reg.number = number;
        wb_reg.size = size;
        wb_reg.data = data;
        tick();
    endtask

    task automatic write_segments(input logic seg_en, input logic [2:0] number,
                                  input logic [15:0] data, input logic cs_en,
                                  input logic [15:0] cs_data);
        wb_seg.en = seg_en;
        wb_seg.number = number;
        wb_seg.data = data;
        write_cs_enable = cs_en;
        write_cs = cs_data;
        tick();
    endtask

    // One compare per output transfer
    initial begin
        decode_pkg::access_bundle_t e;
        forever begin
            @(negedge clk);
            if (!reset && r_valid === 1'b1 && r_ready === 1'b1) begin
                assert (expected_q.size() > 0) else begin
                    $display("Output transfer at %0t ns with no instruction outstanding", $time);
                    stop_on_error();
                end
                e = expected_q.pop_front();
                check_value("r_bundle.instr", {15'd0, r_bundle.instr}, {15'd0, e.instr});
                check_value("r_bundle.op0_sel", {61'd0, r_bundle.op0_sel}, {61'd0, e.op0_sel});
                check_value("r_bundle.op1_sel", {61'd0, r_bundle.op1_sel}, {61'd0, e.op1_sel});
                check_value("r_bundle.op0_value", {32'd0, r_bundle.op0_value},
                            {32'd0, e.op0_value});
                check_value("r_bundle.op1_value", {32'd0, r_bundle.op1_value},
                            {32'd0, e.op1_value});
                check_value("r_bundle.seg_value", {48'd0, r_bundle.seg_value},
                            {48'd0, e.seg_value});
                check_value("r_bundle.stack_address", {32'd0, r_bundle.stack_address},
                            {32'd0, e.stack_address});
            end
        end
    end

    initial begin
        decode_pkg::decode_bundle_t b;
        logic [31:0] r;
        logic [2:0]  dep;
        reset = 1'b1;
        flush = 1'b0;
        write_cs = 16'd0;
        write_cs_enable = 1'b0;
        d_valid = 1'b0;
        d_bundle = '0;
        r_ready = 1'b1;
        wb_reg = '0;
        wb_seg = '0;
        accepted = 1'b0;
        cycle_count = 0;
        esp_m = 32'd0;
        for (int i = 0; i < 8; i++) begin
            regs_m[i] = 32'd0;
            segs_m[i] = 16'd0;
            pending_m[i] = 0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        assert (r_valid === 1'b0 && d_ready === 1'b1) else begin
            $display("Stage not idle after reset: r_valid %b, d_ready %b", r_valid, d_ready);
            stop_on_error();
        end
        for (int i = 0; i < NUM_RESET_INSTR; i++) begin
            send(random_instr());
        end

        // Byte, word and dword writebacks followed by reads
        for (int i = 0; i < NUM_SIZE_INSTR; i++) begin
            r = rand_next();
            write_reg(r[2:0], (r[4:3] == 2'd3) ? regfile_pkg::SIZE_DWORD : {1'b0, r[4:3]},
                      rand_next(), 1'b0);
            b = random_instr();
            if (r[5]) begin
                b.op0_kind = decode_pkg::MODRM_REG;
            end
            b.op1_kind = decode_pkg::REG;
            b.op1_reg = r[2:0];
            send(b);
        end

        for (int i = 0; i < NUM_SEG_INSTR; i++) begin
            r = rand_next();
            write_segments(1'b1, r[2:0] % 3'd6, r[31:16], r[3], r[19:4]);
            send(random_instr());
        end
        // CS writeback and direct CS write in one cycle
        write_segments(1'b1, regfile_pkg::CS_INDEX, 16'h1111, 1'b1, 16'h2222);
        b = random_instr();
        b.seg_override = regfile_pkg::CS_INDEX;
        b.seg_override_valid = 1'b1;
        send(b);

        // Dependent reads wait for the writeback
        for (int i = 0; i < NUM_DEP_PAIRS; i++) begin
            dep = rand_next() % 8;
            b = random_instr();
            b.dest_valid = 1'b1;
            b.dest_reg = dep;
            send(b);
            b = random_instr();
            b.op0_kind = decode_pkg::REG;
            b.op0_reg = dep;
            present(b);
            repeat (3) begin
                tick();
                assert (!accepted) else begin
                    $display("Instruction reading r%0d accepted before its writeback", dep);
                    stop_on_error();
                end
            end
            wb_reg.en = 1'b1;
            wb_reg.stack = 1'b0;
            wb_reg.number = dep;
            wb_reg.size = regfile_pkg::SIZE_DWORD;
            wb_reg.data = rand_next();
            do begin
                tick();
            end while (!accepted);
        end

        // Push and pop addresses with ESP reloads in between
        r = rand_next();
        write_segments(1'b1, regfile_pkg::SS_INDEX, r[31:16], 1'b0, 16'd0);
        write_reg(regfile_pkg::ESP_INDEX, regfile_pkg::SIZE_DWORD, {16'd0, r[15:4], 4'h0}, 1'b0);
        for (int i = 0; i < 2 * NUM_STACK_INSTR; i++) begin
            if (i == NUM_STACK_INSTR) begin
                r = rand_next();
                write_reg(regfile_pkg::ESP_INDEX, regfile_pkg::SIZE_WORD, r, 1'b1);
                write_reg(regfile_pkg::ESP_INDEX, regfile_pkg::SIZE_DWORD,
                          {16'd0, r[31:20], 4'h8}, 1'b0);
            end
            r = rand_next();
            b = random_instr();
            b.size = r[1] ? regfile_pkg::SIZE_WORD : regfile_pkg::SIZE_DWORD;
            b.stack_op.push = r[0];
            b.stack_op.pop = !r[0];
            send(b);
        end

        // Back-pressure holds the output and the next instruction
        repeat (2) tick();
        r_ready = 1'b0;
        send(random_instr());
        present(random_instr());
        repeat (4) begin
            tick();
            assert (!accepted) else begin
                $display("Instruction accepted at %0t ns while the output was held", $time);
                stop_on_error();
            end
        end
        r_ready = 1'b1;
        do begin
            tick();
        end while (!accepted);

        // Flush drops the held output and its pending write
        repeat (2) tick();
        r_ready = 1'b0;
        dep = rand_next() % 8;
        b = random_instr();
        b.dest_valid = 1'b1;
        b.dest_reg = dep;
        send(b);
        repeat (2) tick();
        flush = 1'b1;
        tick();
        assert (r_valid === 1'b0) else begin
            $display("Output still valid at %0t ns after flush", $time);
            stop_on_error();
        end
        r_ready = 1'b1;
        b = random_instr();
        b.op0_kind = decode_pkg::REG;
        b.op0_reg = dep;
        send(b);

        repeat (4) tick();
        assert (expected_q.size() == 0) else begin
            $display("%0d instructions never left the stage", expected_q.size());
            stop_on_error();
        end
        $display("Verification passed");
        $finish;
    end

endmodule
